/* src/cq_desc_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completer request constants for the CQ bridge
// Descriptor field positions and request type codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cq_desc_pkg;

  // Beat geometry
  localparam int cq_data_width = 256;
  localparam int cq_keep_width = 8;   // One keep bit per dword

  // Descriptor layout, first 128 bits of the first beat
  localparam int desc_width    = 128;
  localparam int desc_addr_lsb = 2;
  localparam int desc_addr_msb = 63;
  localparam int desc_size_lsb = 64;  // Dword count, 11 bits
  localparam int desc_type_lsb = 75;  // Request type, 4 bits
  localparam int payload_lsb   = 128; // First payload dword

  // Request type codes
  localparam logic [3:0] req_mem_read       = 4'b0000;
  localparam logic [3:0] req_mem_write      = 4'b0001;
  localparam logic [3:0] req_any_message    = 4'b1100; // Not ATS, not vendor
  localparam logic [3:0] req_vendor_message = 4'b1101;
  localparam logic [3:0] req_ats_message    = 4'b1110;
  localparam logic [3:0] req_reserved       = 4'b1111;

  // Register accesses are a single dword
  localparam logic [10:0] reg_access_size = 11'd1;

endpackage

/* src/cc_desc_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion side constants for the CQ bridge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cc_desc_pkg;

  localparam int cc_data_width = 256;
  localparam int cc_keep_width = 8;

  // Completion status field
  localparam logic [2:0] cpl_status_success     = 3'd0;
  localparam logic [2:0] cpl_status_unsupported = 3'd1;

  // Dword keep patterns
  localparam logic [7:0] keep_read_cpl  = 8'b0000_1111; // Header plus rdata
  localparam logic [7:0] keep_error_cpl = 8'b1111_1111; // Header plus echoed descriptor

  // Length fields
  localparam logic [12:0] cpl_read_bytes   = 13'd4;
  localparam logic [10:0] cpl_error_dwords = 11'd8;
  localparam logic [12:0] cpl_error_bytes  = 13'd32;

endpackage

/* src/cq_request_decoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CQ request decoder
// Registers beats, tracks start of packet and
// classifies the first beat of each request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cq_request_decoder (
  input  logic                                  user_clk,
  input  logic                                  reset_n,
  input  logic                                  cq_tvalid,
  input  logic [cq_desc_pkg::cq_data_width-1:0] cq_tdata,
  input  logic                                  cq_tlast,
  input  logic                                  master_busy,
  output logic                                  cq_tready,
  output logic                                  is_reg_write,
  output logic                                  is_reg_read,
  output logic                                  is_unsupported,
  output logic [cq_desc_pkg::desc_width-1:0]    desc,
  output logic [31:0]                           payload
);
  import cq_desc_pkg::*;

  localparam int kept_width = payload_lsb + 32; // Descriptor and first payload dword

  logic                  sop;
  logic                  beat_first;
  logic [kept_width-1:0] beat_data;
  logic [3:0]            req_type;
  logic [10:0]           req_size;
  logic                  posted;
  logic                  reg_rd_match;
  logic                  wr_q;
  logic                  rd_q;
  logic                  unsup_q;

  assign cq_tready = !master_busy;

  // Start of packet, follows every accepted beat
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      sop <= 1'b1;
    end else if (cq_tvalid && cq_tready) begin
      sop <= cq_tlast;
    end
  end

  // Input stage
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      beat_first <= 1'b0;
    end else if (cq_tready) begin
      beat_first <= cq_tvalid && sop; // Later beats of a packet are dropped here
    end
  end

  always_ff @(posedge user_clk) begin
    if (cq_tready) begin
      beat_data <= cq_tdata[kept_width-1:0];
    end
  end

  assign req_type     = beat_data[desc_type_lsb +: 4];
  assign req_size     = beat_data[desc_size_lsb +: 11];
  assign reg_rd_match = (req_type == req_mem_read) && (req_size == reg_access_size);

  // Posted requests never get a completion, whatever their size
  assign posted = req_type inside {req_mem_write, req_any_message, req_vendor_message,
                                   req_ats_message, req_reserved};

  // Classification stage, held while the master is stalled
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
      unsup_q <= 1'b0;
    end else if (!master_busy) begin
      wr_q    <= beat_first && (req_type == req_mem_write) && (req_size == reg_access_size);
      rd_q    <= beat_first && reg_rd_match;
      unsup_q <= beat_first && !posted && !reg_rd_match;
    end
  end

  always_ff @(posedge user_clk) begin
    if (!master_busy) begin
      desc    <= beat_data[desc_width-1:0];
      payload <= beat_data[payload_lsb +: 32];
    end
  end

  // Pulse only in the cycle the stage hands over
  assign is_reg_write   = wr_q && !master_busy;
  assign is_reg_read    = rd_q && !master_busy;
  assign is_unsupported = unsup_q && !master_busy;

  a_one_pulse: assert property (@(posedge user_clk) disable iff (!reset_n)
    $onehot0({is_reg_write, is_reg_read, is_unsupported}));

endmodule

/* src/read_header_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header FIFO for outstanding register reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module read_header_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                               user_clk,
  input  logic                               reset_n,
  input  logic                               push,
  input  logic [cq_desc_pkg::desc_width-1:0] push_desc,
  input  logic                               pop,
  output logic [cq_desc_pkg::desc_width-1:0] head_desc,
  output logic                               empty,
  output logic                               full
);
  import cq_desc_pkg::*;

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  logic [desc_width-1:0] mem [fifo_depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    next_ptr = (ptr == ptr_width'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge user_clk) begin
    if (push) mem[wr_ptr] <= push_desc;
  end

  assign head_desc = mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == cnt_width'(fifo_depth));

  // Master and builder must respect the flags
  a_no_overflow: assert property (@(posedge user_clk) disable iff (!reset_n) !(push && full));
  a_no_underflow: assert property (@(posedge user_clk) disable iff (!reset_n) !(pop && empty));

endmodule

/* src/axil_reg_master.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite register master
// Turns decoded write and read pulses into held
// AW/W and AR requests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axil_reg_master #(
  parameter int addr_width = 36
) (
  input  logic                               user_clk,
  input  logic                               reset_n,
  input  logic                               is_reg_write,
  input  logic                               is_reg_read,
  input  logic [cq_desc_pkg::desc_width-1:0] desc,
  input  logic [31:0]                        payload,
  input  logic                               awready,
  input  logic                               wready,
  input  logic                               arready,
  input  logic                               fifo_full,
  output logic [addr_width-1:0]              awaddr,
  output logic                               awvalid,
  output logic [31:0]                        wdata,
  output logic                               wvalid,
  output logic [addr_width-1:0]              araddr,
  output logic                               arvalid,
  output logic                               fifo_push,
  output logic                               master_busy
);
  import cq_desc_pkg::*;

  logic [desc_addr_msb:0] req_addr;

  assign req_addr = {desc[desc_addr_msb:desc_addr_lsb], {desc_addr_lsb{1'b0}}}; // Dword aligned

  assign master_busy = (awvalid && !awready) || (wvalid && !wready) ||
                       (arvalid && !arready) || fifo_full;

  // Header is queued as the AR goes out
  assign fifo_push = is_reg_read;

  // Each channel drops its valid on its own handshake
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
    end else if (!master_busy) begin
      awvalid <= is_reg_write;
      wvalid  <= is_reg_write;
      arvalid <= is_reg_read;
    end else begin
      if (awready) awvalid <= 1'b0;
      if (wready) wvalid <= 1'b0;
      if (arready) arvalid <= 1'b0;
    end
  end

  // Loaded only on a new request, held otherwise
  always_ff @(posedge user_clk) begin
    if (is_reg_write) begin
      awaddr <= req_addr[addr_width-1:0];
      wdata  <= payload;
    end
    if (is_reg_read) begin
      araddr <= req_addr[addr_width-1:0];
    end
  end

  a_aw_hold: assert property (@(posedge user_clk) disable iff (!reset_n)
    awvalid && !awready |=> awvalid && $stable(awaddr));
  a_w_hold: assert property (@(posedge user_clk) disable iff (!reset_n)
    wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

/* src/cc_completion_builder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion builder
// Forms read and unsupported-request completions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cc_completion_builder (
  input  logic                                  user_clk,
  input  logic                                  reset_n,
  input  logic                                  is_unsupported,
  input  logic [cq_desc_pkg::desc_width-1:0]    desc,
  input  logic [cq_desc_pkg::desc_width-1:0]    head_desc,
  input  logic                                  fifo_empty,
  input  logic                                  rvalid,
  input  logic [31:0]                           rdata,
  input  logic                                  cc_tready,
  output logic                                  rready,
  output logic                                  fifo_pop,
  output logic                                  cc_tvalid,
  output logic [cc_desc_pkg::cc_data_width-1:0] cc_tdata,
  output logic [cc_desc_pkg::cc_keep_width-1:0] cc_tkeep
);
  import cq_desc_pkg::*;
  import cc_desc_pkg::*;

  logic                  out_free;
  logic                  err_pend;
  logic [desc_width-1:0] err_desc;
  logic [desc_width-1:0] err_src;
  logic                  take_err;

  // Low 96 bits of a completion, shared by both kinds
  function automatic logic [95:0] cpl_header(input logic [desc_width-1:0] d,
                                             input logic [2:0]            status,
                                             input logic [10:0]           dwords,
                                             input logic [12:0]           bytes);
    cpl_header = {1'b0, 3'b000,         // [95:92] attributes
                  d[123:121], 1'b0,     // [91:88] TC
                  8'h00, d[111:104],    // [87:72] bus and target function
                  d[103:96], d[95:80],  // [71:48] tag and requester id
                  2'b00, status,        // [47:43]
                  dwords, 3'b000,       // [42:29]
                  bytes, 6'h00,         // [28:10]
                  d[1:0], 1'b0,         // [9:7] address type
                  d[6:2], 2'b00};       // [6:0] lower address
  endfunction

  assign out_free = !cc_tvalid || cc_tready;
  assign take_err = err_pend || is_unsupported; // Error goes ahead of read data
  assign err_src  = err_pend ? err_desc : desc;
  assign rready   = out_free && !take_err && !fifo_empty;
  assign fifo_pop = rvalid && rready;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      cc_tvalid <= 1'b0;
      err_pend  <= 1'b0;
    end else if (out_free) begin
      cc_tvalid <= take_err || fifo_pop;
      err_pend  <= err_pend && is_unsupported; // Newer error waits behind the pending one
    end else if (is_unsupported) begin
      err_pend <= 1'b1; // Single slot while the output is stalled
    end
  end

  always_ff @(posedge user_clk) begin
    if (out_free) begin
      if (take_err) begin
        cc_tdata <= {err_src, 32'h0,
                     cpl_header(err_src, cpl_status_unsupported, cpl_error_dwords,
                                cpl_error_bytes)};
        cc_tkeep <= keep_error_cpl;
      end else if (fifo_pop) begin
        cc_tdata <= {{(cc_data_width - desc_width){1'b0}}, rdata,
                     cpl_header(head_desc, cpl_status_success, reg_access_size,
                                cpl_read_bytes)};
        cc_tkeep <= keep_read_cpl;
      end
    end
    if (is_unsupported && (!out_free || err_pend)) begin
      err_desc <= desc;
    end
  end

  a_cc_hold: assert property (@(posedge user_clk) disable iff (!reset_n)
    cc_tvalid && !cc_tready |=> cc_tvalid && $stable(cc_tdata) && $stable(cc_tkeep));

endmodule

/* src/cq_axil_bridge.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCIe CQ to AXI4-Lite register bridge, top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cq_axil_bridge #(
  parameter int addr_width = 36,
  parameter int fifo_depth = 4
) (
  input  logic                                  user_clk,
  input  logic                                  reset_n,
  // Completer request stream
  input  logic                                  cq_tvalid,
  input  logic [cq_desc_pkg::cq_data_width-1:0] cq_tdata,
  input  logic                                  cq_tlast,
  output logic                                  cq_tready,
  // AXI4-Lite master
  output logic [addr_width-1:0]                 awaddr,
  output logic [2:0]                            awprot,
  output logic                                  awvalid,
  input  logic                                  awready,
  output logic [31:0]                           wdata,
  output logic [3:0]                            wstrb,
  output logic                                  wvalid,
  input  logic                                  wready,
  input  logic                                  bvalid,  // Write response ignored
  output logic                                  bready,
  output logic [addr_width-1:0]                 araddr,
  output logic [2:0]                            arprot,
  output logic                                  arvalid,
  input  logic                                  arready,
  input  logic [31:0]                           rdata,
  input  logic                                  rvalid,
  output logic                                  rready,
  // Completer completion stream
  output logic                                  cc_tvalid,
  output logic [cc_desc_pkg::cc_data_width-1:0] cc_tdata,
  output logic [cc_desc_pkg::cc_keep_width-1:0] cc_tkeep,
  output logic                                  cc_tlast,
  input  logic                                  cc_tready
);
  import cq_desc_pkg::*;

  logic                  master_busy;
  logic                  is_reg_write;
  logic                  is_reg_read;
  logic                  is_unsupported;
  logic [desc_width-1:0] desc;
  logic [31:0]           payload;
  logic [desc_width-1:0] head_desc;
  logic                  fifo_push;
  logic                  fifo_pop;
  logic                  fifo_full;
  logic                  fifo_empty;

  assign awprot   = 3'b000;
  assign arprot   = 3'b000;
  assign wstrb    = 4'hf;      // Full dword writes only
  assign bready   = cc_tready;
  assign cc_tlast = 1'b1;      // Every completion is one beat

  cq_request_decoder u_decoder (.*);

  axil_reg_master #(.addr_width(addr_width)) u_master (.*);

  read_header_fifo #(.fifo_depth(fifo_depth)) u_hdr_fifo (
    .user_clk  (user_clk),
    .reset_n   (reset_n),
    .push      (fifo_push),
    .push_desc (desc),
    .pop       (fifo_pop),
    .head_desc (head_desc),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  cc_completion_builder u_builder (.*);

endmodule

/* test/tb_clock_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
  output logic user_clk,
  output logic reset_n
);
  initial begin
    user_clk = 1'b0;
    forever #10 user_clk = !user_clk; // 20 ns period
  end

  initial begin
    reset_n = 1'b0;
    repeat (5) @(posedge user_clk);
    #2 reset_n = 1'b1;
  end

endmodule

/* test/tb_cq_axil_bridge.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CQ to AXI4-Lite bridge
// Table driven requests, AXI-Lite slave model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_cq_axil_bridge;
  import cq_desc_pkg::*;
  import cc_desc_pkg::*;

  localparam int addr_width = 36;
  localparam int fifo_depth = 4;
  localparam int max_tests  = 32;

  logic user_clk, reset_n;
  logic cq_tvalid, cq_tlast, cq_tready;
  logic [cq_data_width-1:0] cq_tdata;
  logic [addr_width-1:0] awaddr, araddr;
  logic [2:0] awprot, arprot;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [3:0] wstrb;
  logic cc_tvalid, cc_tlast, cc_tready;
  logic [cc_data_width-1:0] cc_tdata;
  logic [cc_keep_width-1:0] cc_tkeep;

  string       t_name [max_tests];
  string       t_kind [max_tests];
  logic [3:0]  t_type [max_tests];
  logic [10:0] t_size [max_tests];
  logic [63:0] t_addr [max_tests];
  logic [7:0]  t_tag [max_tests];
  logic [15:0] t_reqid [max_tests];
  logic [31:0] t_payload [max_tests];
  int          t_beats [max_tests];
  logic [31:0] t_rdata [max_tests];
  int          t_pending [max_tests];
  bit          t_bad [max_tests];

  int n_tests, errors, tests_ok, tests_bad, cycles, cycle_limit;
  logic [31:0] lfsr = 32'd96264;
  int aw_q[$], w_q[$], ar_q[$], rd_cpl_q[$], err_cpl_q[$];
  logic [31:0] rresp_q[$]; // Read data owed by the slave in AR order

  tb_clock_gen u_clk (.user_clk(user_clk), .reset_n(reset_n));

  cq_axil_bridge #(.addr_width(addr_width), .fifo_depth(fifo_depth)) uut (
    .user_clk(user_clk), .reset_n(reset_n), .cq_tvalid(cq_tvalid), .cq_tdata(cq_tdata),
    .cq_tlast(cq_tlast), .cq_tready(cq_tready), .awaddr(awaddr), .awprot(awprot),
    .awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid),
    .wready(wready), .bvalid(bvalid), .bready(bready), .araddr(araddr), .arprot(arprot),
    .arvalid(arvalid), .arready(arready), .rdata(rdata), .rvalid(rvalid), .rready(rready),
    .cc_tvalid(cc_tvalid), .cc_tdata(cc_tdata), .cc_tkeep(cc_tkeep), .cc_tlast(cc_tlast),
    .cc_tready(cc_tready)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
  endfunction

  // Ready with probability 3/4 from two LFSR steps
  task automatic draw_ready(output logic r);
    logic b0;
    lfsr = lfsr_next(lfsr);
    b0   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    r    = !(b0 && lfsr[0]);
  endtask

  function automatic logic [desc_width-1:0] make_desc(input int t);
    logic [desc_width-1:0] d;
    d = '0;
    d[63:2]   = t_addr[t][63:2];
    d[74:64]  = t_size[t];
    d[78:75]  = t_type[t];
    d[95:80]  = t_reqid[t];
    d[103:96] = t_tag[t];
    return d;
  endfunction

  // Completion header fields as seen on cc_tdata
  function automatic logic [95:0] expect_header(input int t, input logic [2:0] status,
                                                input logic [10:0] dwords,
                                                input logic [12:0] bytes);
    logic [95:0] h;
    h = '0;
    h[6:2]   = t_addr[t][6:2];
    h[28:16] = bytes;
    h[42:32] = dwords;
    h[45:43] = status;
    h[63:48] = t_reqid[t];
    h[71:64] = t_tag[t];
    return h;
  endfunction

  task automatic report_test(input int t);
    if (t_bad[t]) begin
      tests_bad++;
      $display("test %s: FAILED", t_name[t]);
    end else begin
      tests_ok++;
      $display("test %s: ok", t_name[t]);
    end
  endtask

  task automatic mark_error(input int t);
    errors++;
    t_bad[t] = 1'b1;
  endtask

  task automatic event_done(input int t);
    t_pending[t]--;
    if (t_pending[t] == 0) report_test(t);
  endtask

  // Ready and valid outputs right after reset release
  task automatic check_reset_state();
    logic [5:0] act;
    act = {cq_tready, awvalid, wvalid, arvalid, rready, cc_tvalid};
    if (act !== 6'b100000) begin
      $display("Error reset_state: ready/valid expected %b, actual %b", 6'b100000, act);
      errors++;
    end
  endtask

  task automatic check_axil_write(input int t, input logic [addr_width-1:0] act,
                                  input logic [2:0] prot);
    logic [addr_width-1:0] exp;
    exp = {t_addr[t][addr_width-1:2], 2'b00};
    if (act !== exp || prot !== 3'b000) begin
      $display("Error %s: awaddr/awprot expected %h/0, actual %h/%h", t_name[t], exp,
               act, prot);
      mark_error(t);
    end
  endtask

  task automatic check_axil_wdata(input int t, input logic [31:0] act, input logic [3:0] strb);
    if (act !== t_payload[t] || strb !== 4'hf) begin
      $display("Error %s: wdata/wstrb expected %h/f, actual %h/%h", t_name[t],
               t_payload[t], act, strb);
      mark_error(t);
    end
  endtask

  task automatic check_axil_read(input int t, input logic [addr_width-1:0] act,
                                 input logic [2:0] prot);
    logic [addr_width-1:0] exp;
    exp = {t_addr[t][addr_width-1:2], 2'b00};
    if (act !== exp || prot !== 3'b000) begin
      $display("Error %s: araddr/arprot expected %h/0, actual %h/%h", t_name[t], exp,
               act, prot);
      mark_error(t);
    end
  endtask

  task automatic check_completion(input int t, input bit is_err,
                                  input logic [cc_data_width-1:0] act,
                                  input logic [cc_keep_width-1:0] keep,
                                  input logic last);
    logic [cc_data_width-1:0] exp;
    logic [cc_keep_width-1:0] exp_keep;
    if (is_err) begin
      exp = {make_desc(t), 32'h0, expect_header(t, cpl_status_unsupported,
                                                cpl_error_dwords, cpl_error_bytes)};
      exp_keep = keep_error_cpl;
    end else begin
      exp = {128'h0, t_rdata[t], expect_header(t, cpl_status_success, reg_access_size,
                                               cpl_read_bytes)};
      exp_keep = keep_read_cpl;
    end
    if (act !== exp || keep !== exp_keep || last !== 1'b1) begin
      $display("Error %s: completion expected %h/%h/1, actual %h/%h/%b", t_name[t],
               exp_keep, exp, keep, act, last);
      mark_error(t);
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    fd = $fopen("test/bridge_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the request table");
      errors++;
      return;
    end
    while (!$feof(fd) && n_tests < max_tests) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %d %h", t_name[n_tests], t_kind[n_tests],
                    t_type[n_tests], t_size[n_tests], t_addr[n_tests], t_tag[n_tests],
                    t_reqid[n_tests], t_payload[n_tests], t_beats[n_tests], t_rdata[n_tests]);
        if (n == 10) n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic send_request(input int t);
    logic [desc_width-1:0] d;
    logic [desc_width-1:0] ghost;
    d = make_desc(t);
    ghost = d;                        // Later beats look like a register read
    ghost[78:75] = req_mem_read;
    ghost[74:64] = reg_access_size;
    case (t_kind[t])
      "W": begin
        t_pending[t] = 2;
        aw_q.push_back(t);
        w_q.push_back(t);
      end
      "R": begin
        t_pending[t] = 2;
        ar_q.push_back(t);
        rd_cpl_q.push_back(t);
      end
      "E": begin
        t_pending[t] = 1;
        err_cpl_q.push_back(t);
      end
      default: t_pending[t] = 0;
    endcase
    for (int b = 0; b < t_beats[t]; b++) begin
      cq_tvalid = 1'b1;
      cq_tlast  = (b == t_beats[t] - 1);
      cq_tdata  = (b == 0) ? {96'h0, t_payload[t], d} : {{4{t_payload[t]}}, ghost};
      do @(posedge user_clk); while (!cq_tready);
      #2;
    end
    cq_tvalid = 1'b0;
    cq_tlast  = 1'b0;
    if (t_pending[t] == 0) report_test(t);
  endtask

  // Handshake monitor
  always @(posedge user_clk) begin
    int t;
    if (reset_n) begin
      if (awvalid && awready) begin
        if (aw_q.size() == 0) begin
          $display("an AW transfer arrived that no request asked for");
          errors++;
        end else begin
          t = aw_q.pop_front();
          check_axil_write(t, awaddr, awprot);
          event_done(t);
        end
      end
      if (wvalid && wready) begin
        if (w_q.size() == 0) begin
          $display("a W transfer arrived that no request asked for");
          errors++;
        end else begin
          t = w_q.pop_front();
          check_axil_wdata(t, wdata, wstrb);
          event_done(t);
        end
      end
      if (arvalid && arready) begin
        if (ar_q.size() == 0) begin
          $display("an AR transfer arrived that no request asked for");
          errors++;
        end else begin
          t = ar_q.pop_front();
          check_axil_read(t, araddr, arprot);
          rresp_q.push_back(t_rdata[t]);
          event_done(t);
        end
      end
      if (rvalid && rready) void'(rresp_q.pop_front());
      if (cc_tvalid && cc_tready) begin
        if (cc_tkeep == keep_error_cpl && err_cpl_q.size() != 0) begin
          t = err_cpl_q.pop_front();
          check_completion(t, 1'b1, cc_tdata, cc_tkeep, cc_tlast);
          event_done(t);
        end else if (cc_tkeep != keep_error_cpl && rd_cpl_q.size() != 0) begin
          t = rd_cpl_q.pop_front();
          check_completion(t, 1'b0, cc_tdata, cc_tkeep, cc_tlast);
          event_done(t);
        end else begin
          $display("a completion arrived that no request asked for");
          errors++;
        end
      end
      if (bready !== cc_tready) begin
        $display("Error bready: expected %b, actual %b", cc_tready, bready);
        errors++;
      end
      if (((awvalid && !awready) || (wvalid && !wready) || (arvalid && !arready)) &&
          cq_tready) begin
        $display("cq_tready was high while an AXI request was stalled");
        errors++;
      end
    end
  end

  // Slave model drives readies and read data 2 ns after the edge
  initial begin
    forever begin
      @(posedge user_clk);
      #2;
      draw_ready(awready);
      draw_ready(wready);
      draw_ready(arready);
      draw_ready(cc_tready);
      rvalid = (rresp_q.size() != 0);
      rdata  = rvalid ? rresp_q[0] : 32'h0;
    end
  end

  initial begin
    forever begin
      @(posedge user_clk);
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
        $display("run stopped after %0d cycles without finishing", cycle_limit);
        $display("tests failed");
        $finish;
      end
    end
  end

  initial begin
    cq_tvalid = 1'b0;
    cq_tdata  = '0;
    cq_tlast  = 1'b0;
    awready   = 1'b0;
    wready    = 1'b0;
    arready   = 1'b0;
    bvalid    = 1'b0;
    rvalid    = 1'b0;
    rdata     = 32'h0;
    cc_tready = 1'b0;
    load_tests();
    cycle_limit = 64 * n_tests + 16; // Reset cycles on top
    wait (reset_n);
    check_reset_state();
    @(posedge user_clk);
    #2;
    for (int t = 0; t < n_tests; t++) send_request(t);
    while (aw_q.size() + w_q.size() + ar_q.size() + rd_cpl_q.size() + err_cpl_q.size() != 0)
      @(posedge user_clk);
    repeat (20) @(posedge user_clk); // Quiet window for stray traffic
    $display("%0d tests: %0d ok, %0d bad, %0d errors", n_tests, tests_ok, tests_bad, errors);
    if (errors == 0 && n_tests > 0 && tests_ok == n_tests) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* test/bridge_input.txt */
# name kind type size addr tag reqid payload beats rdata (all hex except beats)
# kind W register write, R register read, E unsupported request, N no traffic
wr_basic W 1 1 0000001234 01 0100 deadbeef 1 00000000
rd_basic R 0 1 0000000104 02 0100 00000000 1 cafe0001
rd_size4 E 0 4 0000000200 03 0101 00000000 1 00000000
wr_hi_addr W 1 1 f00000abc8 04 0200 12345678 1 00000000
wr_size8 N 1 8 0000000400 05 0201 11111111 2 00000000
msg_any N c 0 0000000000 06 0202 00000000 1 00000000
rd_hi_addr R 0 1 a000000048 07 0203 00000000 1 cafe0002
io_read E 2 1 0000000300 08 0300 00000000 1 00000000
msg_vendor N d 2 0000000000 09 0301 00000000 2 00000000
rd_a R 0 1 0000000500 0a 0400 00000000 1 cafe00aa
rd_b R 0 1 0000000504 0b 0400 00000000 1 cafe00bb
rd_c R 0 1 0000000508 0c 0401 00000000 1 cafe00cc
rd_d R 0 1 000000050c 0d 0401 00000000 1 cafe00dd
rd_e R 0 1 0000000510 0e 0402 00000000 1 cafe00ee
msg_ats N e 0 0000000000 10 0500 00000000 1 00000000
reserved N f 1 0000000000 11 0501 00000000 3 00000000
wr_multi N 1 a 0000000700 12 0502 22222222 3 00000000
atomic_op E 3 1 0000000600 0f 0403 00000000 1 00000000
wr_last W 1 1 0000000ffc 13 0600 a5a5a5a5 1 00000000

/* flist.f */
src/cq_desc_pkg.sv
src/cc_desc_pkg.sv
src/cq_request_decoder.sv
src/read_header_fifo.sv
src/axil_reg_master.sv
src/cc_completion_builder.sv
src/cq_axil_bridge.sv
test/tb_clock_gen.sv
test/tb_cq_axil_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cq_axil_bridge
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
